//--- tb.f
commit_pkg.sv
commit_decoder.sv
commit_ctrl.sv
arch_reg_file.sv
trap_unit.sv
commit_top.sv
commit_chk.sv
tb_commit.sv

//--- Bender.yml
package:
  name: commit_stage

sources:
  - files:
      - commit_pkg.sv
      - commit_decoder.sv
      - commit_ctrl.sv
      - arch_reg_file.sv
      - trap_unit.sv
      - commit_top.sv
  - target: test
    files:
      - commit_chk.sv
      - tb_commit.sv

//--- tb_commit.sv
`timescale 1ns/1ps

module tb_commit;

    import commit_pkg::*;

    // expected retirement effect of a row
    localparam logic [2:0] K_INT    = 3'd0;
    localparam logic [2:0] K_FP     = 3'd1;
    localparam logic [2:0] K_STORE  = 3'd2;
    localparam logic [2:0] K_SILENT = 3'd3;
    localparam logic [2:0] K_FLUSH  = 3'd4;
    localparam logic [2:0] K_TRAP   = 3'd5;

    // one table row of stimulus then expectation
    typedef struct packed {
        logic [6:0]  opcode;
        logic [63:0] pc;
        logic [4:0]  rd;
        logic [63:0] value;
        logic        exc;
        logic [3:0]  code;
        logic [2:0]  kind;
        logic [63:0] exp;
        logic [3:0]  delay;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              rob_valid;
    rob_entry_t        rob_entry;
    logic              rob_ready;
    logic              sb_valid;
    logic              sb_ready;
    logic              flush;
    logic [63:0]       redirect_pc;
    logic [63:0]       mepc;
    logic [3:0]        mcause;
    logic [4:0]        int_raddr;
    logic [63:0]       int_rdata;
    logic [4:0]        fp_raddr;
    logic [63:0]       fp_rdata;

    row_t              rows[$];
    logic [63:0]       int_model[32];
    logic [63:0]       fp_model[32];
    logic [63:0]       mepc_exp;
    logic [3:0]        mcause_exp;
    integer            seed;
    int                errors;
    int                cycles;
    int                limit;
    int                max_delay;

    commit_top #(
        .MTVEC_BASE     (64'h8000_0000),
        .RF_RESET_VALUE (64'h0)
    ) commit_top_i (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .rob_valid_i   (rob_valid),
        .rob_entry_i   (rob_entry),
        .rob_ready_o   (rob_ready),
        .sb_valid_o    (sb_valid),
        .sb_ready_i    (sb_ready),
        .flush_o       (flush),
        .redirect_pc_o (redirect_pc),
        .mepc_o        (mepc),
        .mcause_o      (mcause),
        .int_raddr_i   (int_raddr),
        .int_rdata_o   (int_rdata),
        .fp_raddr_i    (fp_raddr),
        .fp_rdata_o    (fp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog with its limit set once the table is built
    always @(posedge clk) begin : watchdog
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic add_row(input logic [6:0] opcode, input logic [63:0] pc, input logic [4:0] rd,
                           input logic [63:0] value, input logic exc, input logic [3:0] code,
                           input logic [2:0] kind, input logic [63:0] exp);
        row_t r;
        r = '0;
        r.opcode = opcode;
        r.pc     = pc;
        r.rd     = rd;
        r.value  = value;
        r.exc    = exc;
        r.code   = code;
        r.kind   = kind;
        r.exp    = exp;
        // store buffer answers after a random wait
        if (kind == K_STORE) begin
            r.delay = $unsigned($random(seed)) % 6;
        end
        if (r.delay > max_delay) begin
            max_delay = r.delay;
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(OPCODE_OP,        64'h100, 5'd5,  64'hcafe_0005, 0, 0, K_INT, 64'hcafe_0005);
        add_row(OPCODE_OP_IMM,    64'h104, 5'd6,  64'hcafe_0006, 0, 0, K_INT, 64'hcafe_0006);
        add_row(OPCODE_LOAD,      64'h108, 5'd7,  64'hffff_fff7, 0, 0, K_INT, 64'hffff_fff7);
        // x0 write is dropped
        add_row(OPCODE_LUI,       64'h10c, 5'd0,  64'h1234_5000, 0, 0, K_INT, 64'h1234_5000);
        add_row(OPCODE_LOAD_FP,   64'h110, 5'd3,  64'h3ff0_0000, 0, 0, K_FP,  64'h3ff0_0000);
        add_row(OPCODE_OP_FP,     64'h114, 5'd4,  64'h4000_0004, 0, 0, K_FP,  64'h4000_0004);
        // stores point rd at live registers that must stay untouched
        add_row(OPCODE_STORE,     64'h118, 5'd5,  64'h5555, 0, 0, K_STORE, 64'h0);
        add_row(OPCODE_JAL,       64'h11c, 5'd1,  64'h120, 0, 0, K_INT, 64'h120);
        // correctly predicted branch
        add_row(OPCODE_BRANCH,    64'h120, 5'd0,  64'h0010_0000, 0, 0, K_SILENT, 64'h0);
        add_row(OPCODE_OP_32,     64'h124, 5'd8,  64'hcafe_0008, 0, 0, K_INT, 64'hcafe_0008);
        // mispredict bit set and target field 0x200918 gives pc 0x401230
        add_row(OPCODE_BRANCH,    64'h128, 5'd0,  64'h8000_0000_0020_0918, 0, 0, K_FLUSH,
                64'h40_1230);
        add_row(OPCODE_STORE_FP,  64'h12c, 5'd4,  64'h6666, 0, 0, K_STORE, 64'h0);
        // traps go to base plus four times the cause
        add_row(OPCODE_OP,        64'h130, 5'd5,  64'hbad0_0005, 1, 2, K_TRAP, 64'h8000_0008);
        add_row(OPCODE_STORE,     64'h134, 5'd0,  64'h7777, 1, 6, K_TRAP, 64'h8000_0018);
        add_row(OPCODE_LOAD_FP,   64'h138, 5'd3,  64'hbad0_0003, 1, 5, K_TRAP, 64'h8000_0014);
        add_row(OPCODE_AUIPC,     64'h13c, 5'd9,  64'hcafe_0009, 0, 0, K_INT, 64'hcafe_0009);
        add_row(7'h7f,            64'h140, 5'd10, 64'hcafe_000a, 0, 0, K_SILENT, 64'h0);
    endtask

    task automatic drive_row(input int idx);
        rob_entry_t e;
        e               = '0;
        e.pc            = rows[idx].pc;
        e.instr         = {20'h0, rows[idx].rd, rows[idx].opcode};
        e.rd_idx        = rows[idx].rd;
        e.value.result  = rows[idx].value;
        e.except_raised = rows[idx].exc;
        e.except_code   = rows[idx].code;
        rob_entry       = e;
        rob_valid       = 1'b1;
    endtask

    // returns 1 ns after the edge that takes the entry
    task automatic wait_accept();
        do begin
            @(negedge clk);
        end while (!(rob_ready && !flush));
        @(posedge clk);
        #1;
    endtask

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            K_INT:   return "int write";
            K_FP:    return "fp write";
            K_STORE: return "store";
            K_FLUSH: return "mispredict";
            K_TRAP:  return "exception";
            default: return "silent";
        endcase
    endfunction

    initial begin : main
        int   err_before;
        int   n_pass;
        int   n_fail;
        bit   pend;
        row_t r;
        n_pass     = 0;
        n_fail     = 0;
        pend       = 1'b0;
        errors     = 0;
        cycles     = 0;
        limit      = 0;
        max_delay  = 0;
        seed       = 32'h4304;
        mepc_exp   = '0;
        mcause_exp = '0;
        rst_n      = 1'b0;
        rob_valid  = 1'b0;
        rob_entry  = '0;
        sb_ready   = 1'b0;
        int_raddr  = '0;
        fp_raddr   = '0;
        for (int k = 0; k < 32; k++) begin
            int_model[k] = '0;
            fp_model[k]  = '0;
        end
        build_table();
        limit = rows.size() * (max_delay + 4) + 50;

        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        // idle state straight after reset
        err_before = errors;
        @(negedge clk);
        check("rob_ready_o", rob_ready, 1);
        check("flush_o", flush, 0);
        check("sb_valid_o", sb_valid, 0);
        check("mepc_o", mepc, 0);
        check("mcause_o", mcause, 0);
        // one read address per cycle
        for (int k = 0; k < 32; k++) begin
            @(posedge clk);
            #1;
            int_raddr = k;
            fp_raddr  = k;
            @(negedge clk);
            check("int_rdata_o", int_rdata, 0);
            check("fp_rdata_o", fp_rdata, 0);
        end
        if (errors == err_before) begin
            n_pass = n_pass + 1;
        end else begin
            n_fail = n_fail + 1;
        end
        $display("test reset state: %s", (errors == err_before) ? "ok" : "FAIL");

        @(posedge clk);
        #1;
        drive_row(0);
        for (int i = 0; i < rows.size(); i++) begin
            r          = rows[i];
            err_before = errors;
            if (!pend) begin
                wait_accept();
            end
            // plain rows let the next entry follow on the very next edge
            if (i + 1 < rows.size() && r.kind inside {K_INT, K_FP, K_SILENT}) begin
                drive_row(i + 1);
            end else begin
                rob_valid = 1'b0;
            end
            int_raddr = r.rd;
            fp_raddr  = r.rd;
            if (r.kind == K_STORE) begin
                // store holds the head until the store buffer takes it
                repeat (r.delay) begin
                    @(negedge clk);
                    check("sb_valid_o", sb_valid, 1);
                    check("rob_ready_o", rob_ready, 0);
                    @(posedge clk);
                    #1;
                end
                sb_ready = 1'b1;
                @(negedge clk);
                check("sb_valid_o", sb_valid, 1);
                check("flush_o", flush, 0);
                @(posedge clk);
                #1;
                sb_ready = 1'b0;
                pend     = 1'b0;
            end else begin
                @(negedge clk);
                check("flush_o", flush, (r.kind == K_FLUSH || r.kind == K_TRAP));
                check("sb_valid_o", sb_valid, 0);
                check("rob_ready_o", rob_ready, 1);
                if (r.kind == K_FLUSH || r.kind == K_TRAP) begin
                    check("redirect_pc_o", redirect_pc, r.exp);
                end
                pend = rob_valid && rob_ready && !flush;
                @(posedge clk);
                #1;
            end
            // expected architectural state after the retiring edge
            if (r.kind == K_INT && r.rd != 0) begin
                int_model[r.rd] = r.exp;
            end
            if (r.kind == K_FP && r.rd != 0) begin
                fp_model[r.rd] = r.exp;
            end
            if (r.kind == K_TRAP) begin
                mepc_exp   = r.pc;
                mcause_exp = r.code;
            end
            check("int_rdata_o", int_rdata, int_model[r.rd]);
            check("fp_rdata_o", fp_rdata, fp_model[r.rd]);
            check("mepc_o", mepc, mepc_exp);
            check("mcause_o", mcause, mcause_exp);
            if (!pend && i + 1 < rows.size()) begin
                drive_row(i + 1);
            end
            if (errors == err_before) begin
                n_pass = n_pass + 1;
            end else begin
                n_fail = n_fail + 1;
            end
            $display("test %0d %s: %s", i, kind_name(r.kind),
                     (errors == err_before) ? "ok" : "FAIL");
        end

        $display("%0d tests passed, %0d tests failed, %0d check errors", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- commit_chk.sv
`timescale 1ns/1ps

module commit_chk (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               rob_ready_o,
    input  logic               sb_valid_o,
    input  logic               sb_ready_i,
    input  logic               flush_o,
    input  logic               trap_take_o,
    input  commit_pkg::rf_wr_t int_wr_o,
    input  commit_pkg::rf_wr_t fp_wr_o
);

    // trap cycle, flush without any architectural write
    no_write_on_trap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (flush_o && trap_take_o) |-> !(int_wr_o.en || fp_wr_o.en))
        else $error("register write during a trap flush");

    // store request held until the store buffer takes it
    sb_valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (sb_valid_o && !sb_ready_i) |=> sb_valid_o)
        else $error("sb_valid_o dropped before sb_ready_i");

    // empty commit register out of reset
    ready_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> rob_ready_o)
        else $error("rob_ready_o low in first cycle after reset");

    // one result, one file
    one_rf_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(int_wr_o.en && fp_wr_o.en))
        else $error("int and fp register writes in the same cycle");

endmodule

bind commit_ctrl commit_chk commit_chk_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rob_ready_o (rob_ready_o),
    .sb_valid_o  (sb_valid_o),
    .sb_ready_i  (sb_ready_i),
    .flush_o     (flush_o),
    .trap_take_o (trap_take_o),
    .int_wr_o    (int_wr_o),
    .fp_wr_o     (fp_wr_o)
);

//--- commit_top.sv
`timescale 1ns/1ps

module commit_top #(
    parameter logic [commit_pkg::XLEN-1:0] MTVEC_BASE     = 64'h8000_0000,
    parameter logic [commit_pkg::XLEN-1:0] RF_RESET_VALUE = '0
) (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    // rob side
    input  logic                                    rob_valid_i,
    input  commit_pkg::rob_entry_t                  rob_entry_i,
    output logic                                    rob_ready_o,
    // store buffer side
    output logic                                    sb_valid_o,
    input  logic                                    sb_ready_i,
    // fetch redirect
    output logic                                    flush_o,
    output logic [commit_pkg::XLEN-1:0]             redirect_pc_o,
    // trap registers
    output logic [commit_pkg::XLEN-1:0]             mepc_o,
    output logic [commit_pkg::EXC_CODE_LEN-1:0]     mcause_o,
    // register file read ports
    input  logic [commit_pkg::REG_IDX_LEN-1:0]      int_raddr_i,
    output logic [commit_pkg::XLEN-1:0]             int_rdata_o,
    input  logic [commit_pkg::REG_IDX_LEN-1:0]      fp_raddr_i,
    output logic [commit_pkg::XLEN-1:0]             fp_rdata_o
);

    import commit_pkg::*;

    logic [OPCODE_LEN-1:0]   opcode;
    commit_cls_t             cls;
    rf_wr_t                  int_wr;
    rf_wr_t                  fp_wr;
    logic                    trap_take;
    logic [XLEN-1:0]         trap_epc;
    logic [EXC_CODE_LEN-1:0] trap_code;
    logic [XLEN-1:0]         trap_pc;

    commit_ctrl u_commit_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rob_valid_i   (rob_valid_i),
        .rob_entry_i   (rob_entry_i),
        .rob_ready_o   (rob_ready_o),
        .cls_i         (cls),
        .opcode_o      (opcode),
        .sb_valid_o    (sb_valid_o),
        .sb_ready_i    (sb_ready_i),
        .int_wr_o      (int_wr),
        .fp_wr_o       (fp_wr),
        .trap_take_o   (trap_take),
        .trap_epc_o    (trap_epc),
        .trap_code_o   (trap_code),
        .trap_pc_i     (trap_pc),
        .flush_o       (flush_o),
        .redirect_pc_o (redirect_pc_o)
    );

    // decoder sees only the opcode, upper bits tied off
    commit_decoder u_commit_decoder (
        .instr_i ({{(32-OPCODE_LEN){1'b0}}, opcode}),
        .cls_o   (cls)
    );

    arch_reg_file #(
        .RF_RESET_VALUE (RF_RESET_VALUE)
    ) int_rf (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (int_wr),
        .raddr_i (int_raddr_i),
        .rdata_o (int_rdata_o)
    );

    arch_reg_file #(
        .RF_RESET_VALUE (RF_RESET_VALUE)
    ) fp_rf (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (fp_wr),
        .raddr_i (fp_raddr_i),
        .rdata_o (fp_rdata_o)
    );

    trap_unit #(
        .MTVEC_BASE (MTVEC_BASE)
    ) u_trap_unit (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .take_i    (trap_take),
        .epc_i     (trap_epc),
        .code_i    (trap_code),
        .trap_pc_o (trap_pc),
        .mepc_o    (mepc_o),
        .mcause_o  (mcause_o)
    );

endmodule

//--- trap_unit.sv
`timescale 1ns/1ps

module trap_unit #(
    parameter logic [commit_pkg::XLEN-1:0] MTVEC_BASE = '0
) (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    // trap request from commit
    input  logic                                    take_i,
    input  logic [commit_pkg::XLEN-1:0]             epc_i,
    input  logic [commit_pkg::EXC_CODE_LEN-1:0]     code_i,
    // handler address
    output logic [commit_pkg::XLEN-1:0]             trap_pc_o,
    // machine trap registers
    output logic [commit_pkg::XLEN-1:0]             mepc_o,
    output logic [commit_pkg::EXC_CODE_LEN-1:0]     mcause_o
);

    import commit_pkg::*;

    logic [XLEN-1:0]         vec_offset;
    logic [XLEN-1:0]         mepc_q;
    logic [EXC_CODE_LEN-1:0] mcause_q;

    // vectored mode, one word per cause
    assign vec_offset = {{(XLEN-EXC_CODE_LEN-2){1'b0}}, code_i, 2'b00};
    assign trap_pc_o  = MTVEC_BASE + vec_offset;

    // captured on the retiring edge of the faulting entry
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (take_i) begin
            mepc_q   <= epc_i;
            mcause_q <= code_i;
        end
    end

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

endmodule

//--- arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file #(
    parameter logic [commit_pkg::XLEN-1:0] RF_RESET_VALUE = '0
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // commit write port
    input  commit_pkg::rf_wr_t                  wr_i,
    // read port
    input  logic [commit_pkg::REG_IDX_LEN-1:0]  raddr_i,
    output logic [commit_pkg::XLEN-1:0]         rdata_o
);

    import commit_pkg::*;

    localparam int unsigned NUM_REGS = 2 ** REG_IDX_LEN;

    // architectural state
    logic [XLEN-1:0] regs [NUM_REGS];

    logic            wr_en;

    // x0 is hardwired, drop its writes here
    assign wr_en = wr_i.en & (wr_i.idx != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= RF_RESET_VALUE;
            end
        end else if (wr_en) begin
            // one commit per cycle, no port conflict
            regs[wr_i.idx] <= wr_i.data;
        end
    end

    // async read
    // entry 0 reads zero whatever is stored there
    always_comb begin : rd_port
        if (raddr_i == '0) begin
            rdata_o = '0;
        end else begin
            rdata_o = regs[raddr_i];
        end
    end

endmodule

//--- commit_ctrl.sv
`timescale 1ns/1ps

module commit_ctrl (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    // rob head
    input  logic                                    rob_valid_i,
    input  commit_pkg::rob_entry_t                  rob_entry_i,
    output logic                                    rob_ready_o,
    // decoder
    input  commit_pkg::commit_cls_t                 cls_i,
    output logic [commit_pkg::OPCODE_LEN-1:0]       opcode_o,
    // store buffer
    output logic                                    sb_valid_o,
    input  logic                                    sb_ready_i,
    // register file writes
    output commit_pkg::rf_wr_t                      int_wr_o,
    output commit_pkg::rf_wr_t                      fp_wr_o,
    // trap unit
    output logic                                    trap_take_o,
    output logic [commit_pkg::XLEN-1:0]             trap_epc_o,
    output logic [commit_pkg::EXC_CODE_LEN-1:0]     trap_code_o,
    input  logic [commit_pkg::XLEN-1:0]             trap_pc_i,
    // fetch redirect
    output logic                                    flush_o,
    output logic [commit_pkg::XLEN-1:0]             redirect_pc_o
);

    import commit_pkg::*;

    // commit register, payload and occupancy
    rob_entry_t      entry_q;
    logic            full_q;

    logic            except;
    logic            mispredict;
    logic            retire;
    logic            accept;
    logic [XLEN-1:0] branch_pc;

    // held opcode to the decoder, class comes back same cycle
    assign opcode_o = entry_q.instr[OPCODE_LEN-1:0];

    // exception overrides every class effect
    assign except = full_q & entry_q.except_raised;

    // branch view of the value slot
    assign mispredict = full_q & ~except & cls_i.is_branch & entry_q.value.branch.mispredict;
    assign branch_pc  = {entry_q.value.branch.target, 1'b0};

    // store waits for the store buffer, anything else leaves at once
    assign sb_valid_o = full_q & ~except & cls_i.is_store;
    assign retire     = full_q & (~sb_valid_o | sb_ready_i);

    // room when empty or when the head leaves this cycle
    assign rob_ready_o = ~full_q | retire;

    // redirect on mispredict or trap
    assign flush_o       = except | mispredict;
    assign redirect_pc_o = except ? trap_pc_i : branch_pc;

    // entry offered during a flush belongs to the wrong path
    assign accept = rob_valid_i & rob_ready_o & ~flush_o;

    // result view of the value slot
    always_comb begin : rf_write
        int_wr_o.en   = retire & ~except & cls_i.wr_int;
        int_wr_o.idx  = entry_q.rd_idx;
        int_wr_o.data = entry_q.value.result;
        fp_wr_o.en    = retire & ~except & cls_i.wr_fp;
        fp_wr_o.idx   = entry_q.rd_idx;
        fp_wr_o.data  = entry_q.value.result;
    end

    // trap info straight from the held entry
    // an excepting entry always retires in its first cycle
    assign trap_take_o = except;
    assign trap_epc_o  = entry_q.pc;
    assign trap_code_o = entry_q.except_code;

    // occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (retire) begin
            full_q <= 1'b0;
        end
    end

    // payload only loads on handshake
    always_ff @(posedge clk_i) begin
        if (accept) begin
            entry_q <= rob_entry_i;
        end
    end

endmodule

//--- commit_decoder.sv
`timescale 1ns/1ps

module commit_decoder (
    input  logic [31:0]               instr_i,
    output commit_pkg::commit_cls_t   cls_o
);

    import commit_pkg::*;

    logic [OPCODE_LEN-1:0] opcode;

    // only the major opcode matters at commit
    assign opcode = instr_i[OPCODE_LEN-1:0];

    always_comb begin : cls_decode
        // default is a silent retire
        cls_o = '0;
        case (opcode)
            // integer results, jumps write the link register
            OPCODE_OP,
            OPCODE_OP_IMM,
            OPCODE_OP_32,
            OPCODE_OP_IMM_32,
            OPCODE_LUI,
            OPCODE_AUIPC,
            OPCODE_JAL,
            OPCODE_JALR,
            OPCODE_LOAD: begin
                cls_o.wr_int = 1'b1;
            end

            // fp results
            OPCODE_LOAD_FP,
            OPCODE_OP_FP: begin
                cls_o.wr_fp = 1'b1;
            end

            // both store kinds go out through the store buffer
            OPCODE_STORE,
            OPCODE_STORE_FP: begin
                cls_o.is_store = 1'b1;
            end

            // conditional branches may redirect fetch
            OPCODE_BRANCH: begin
                cls_o.is_branch = 1'b1;
            end

            default: begin
                // unknown opcode, nothing to do
                cls_o = '0;
            end
        endcase
    end

endmodule

//--- commit_pkg.sv
package commit_pkg;

    // datapath and field widths
    localparam int unsigned XLEN         = 64;
    localparam int unsigned REG_IDX_LEN  = 5;
    localparam int unsigned OPCODE_LEN   = 7;
    localparam int unsigned EXC_CODE_LEN = 4;

    // major opcodes, instr[6:0]
    localparam logic [OPCODE_LEN-1:0] OPCODE_OP        = 7'b0110011;
    localparam logic [OPCODE_LEN-1:0] OPCODE_OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_LEN-1:0] OPCODE_OP_32     = 7'b0111011;
    localparam logic [OPCODE_LEN-1:0] OPCODE_OP_IMM_32 = 7'b0011011;
    localparam logic [OPCODE_LEN-1:0] OPCODE_LUI       = 7'b0110111;
    localparam logic [OPCODE_LEN-1:0] OPCODE_AUIPC     = 7'b0010111;
    localparam logic [OPCODE_LEN-1:0] OPCODE_JAL       = 7'b1101111;
    localparam logic [OPCODE_LEN-1:0] OPCODE_JALR      = 7'b1100111;
    localparam logic [OPCODE_LEN-1:0] OPCODE_LOAD      = 7'b0000011;
    localparam logic [OPCODE_LEN-1:0] OPCODE_LOAD_FP   = 7'b0000111;
    localparam logic [OPCODE_LEN-1:0] OPCODE_OP_FP     = 7'b1010011;
    localparam logic [OPCODE_LEN-1:0] OPCODE_STORE     = 7'b0100011;
    localparam logic [OPCODE_LEN-1:0] OPCODE_STORE_FP  = 7'b0100111;
    localparam logic [OPCODE_LEN-1:0] OPCODE_BRANCH    = 7'b1100011;

    // branch resolution as written back by the branch unit
    // target is halfword aligned, bit 0 not stored
    typedef struct packed {
        logic            mispredict;
        logic [XLEN-2:0] target;
    } branch_res_t;

    // rob value slot, meaning depends on the instruction class
    typedef union packed {
        logic [XLEN-1:0] result;
        branch_res_t     branch;
    } rob_value_u;

    // rob head entry
    typedef struct packed {
        logic [XLEN-1:0]         pc;
        logic [31:0]             instr;
        logic [REG_IDX_LEN-1:0]  rd_idx;
        rob_value_u              value;
        logic                    except_raised;
        logic [EXC_CODE_LEN-1:0] except_code;
    } rob_entry_t;

    // retirement class
    // all zero means retire with no side effect
    typedef struct packed {
        logic wr_int;
        logic wr_fp;
        logic is_store;
        logic is_branch;
    } commit_cls_t;

    // commit write request into an architectural register file
    typedef struct packed {
        logic                   en;
        logic [REG_IDX_LEN-1:0] idx;
        logic [XLEN-1:0]        data;
    } rf_wr_t;

endpackage
